// ==== sim.f ====
+incdir+common
common/riscv_pkg.sv
common/core_pkg.sv
logic/bit_oh_or.sv
logic/alu_inst_decoder.sv
logic/phys_regfile.sv
alu_pipe/alu_pipe.sv
logic/alu_subsystem_top.sv
tests/tb_alu_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_alu_subsystem -Mdir obj_dir -o sim_tb

out=$(./obj_dir/sim_tb) || { echo "$out"; exit 1; }
echo "$out"

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== tests/tb_alu_subsystem.sv ====
`timescale 1ns/10ps
`include "core_settings.svh"

module tb_alu_subsystem;

  localparam int N_DIRECTED = 17;
  localparam int N_RANDOM   = 400;
  localparam int MAX_CYCLES = (N_DIRECTED + N_RANDOM) * 2 + 50;

  localparam logic [2:0] K_LUI   = 3'd0;
  localparam logic [2:0] K_AUIPC = 3'd1;
  localparam logic [2:0] K_ADD   = 3'd2;
  localparam logic [2:0] K_SUB   = 3'd3;
  localparam logic [2:0] K_ADDI  = 3'd4;

  // one instruction in flight, as the testbench sees it
  typedef struct packed {
    logic [31:0]               issue_cyc;
    logic [2:0]                kind;
    logic                      rd_valid;
    logic [`RNID_W-1:0]        rd;
    logic                      rs1_valid;
    logic [`RNID_W-1:0]        rs1;
    logic                      rs2_valid;
    logic [`RNID_W-1:0]        rs2;
    logic [19:0]               imm20;
    logic [11:0]               imm12;
    logic [`XLEN-1:0]          pc;
    logic [`RV_ENTRY_SIZE-1:0] index;
    logic [`XLEN-1:0]          exp_data;
  } flight_t;

  logic                      i_clk;
  logic                      i_reset_n;
  core_pkg::issue_t          i_issue;
  logic [`RV_ENTRY_SIZE-1:0] i_index;
  core_pkg::target_t         i_ext_target;
  core_pkg::release_t        o_release;
  core_pkg::target_t         o_target;
  logic                      o_done;
  logic [`RV_ENTRY_SIZE-1:0] o_done_index;

  logic [`XLEN-1:0] model [`RNID_SIZE];
  flight_t          q [$];
  logic [31:0]      cyc;
  logic [31:0]      rng_state;
  int               n_issued;
  int               n_checks;
  int               n_errors;
  int               cycle_count;
  bit               checking;

  alu_subsystem_top dut0 (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_issue      (i_issue),
    .i_index      (i_index),
    .i_ext_target (i_ext_target),
    .o_release    (o_release),
    .o_target     (o_target),
    .o_done       (o_done),
    .o_done_index (o_done_index)
  );

  always #20 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count > MAX_CYCLES) begin
      $display("timeout after %0d cycles, %0d instructions never completed",
               cycle_count, q.size());
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int find_at(input logic [31:0] at);
    for (int k = 0; k < q.size(); k++) begin
      if (q[k].issue_cyc == at) return k;
    end
    return -1;
  endfunction

  // a producer two cycles ahead would be read stale
  function automatic bit needs_bubble(input flight_t f);
    int p;
    p = find_at(cyc - 1);
    if (p < 0 || !q[p].rd_valid) return 1'b0;
    return (f.rs1_valid && f.rs1 == q[p].rd) || (f.rs2_valid && f.rs2 == q[p].rd);
  endfunction

  function automatic flight_t make_inst(input logic [2:0] kind, input logic [`RNID_W-1:0] rd,
                                        input logic [`RNID_W-1:0] rs1,
                                        input logic [`RNID_W-1:0] rs2,
                                        input logic [31:0] imm, input logic [`XLEN-1:0] pc);
    flight_t f;
    f = '0;
    f.kind      = kind;
    f.rd_valid  = 1'b1;
    f.rd        = rd;
    f.rs1_valid = (kind == K_ADD) || (kind == K_SUB) || (kind == K_ADDI);
    f.rs1       = rs1;
    f.rs2_valid = (kind == K_ADD) || (kind == K_SUB);
    f.rs2       = rs2;
    f.imm20     = imm[19:0];
    f.imm12     = imm[11:0];
    f.pc        = pc;
    return f;
  endfunction

  function automatic core_pkg::issue_t build_issue(input flight_t f);
    core_pkg::issue_t s;
    riscv_pkg::inst_t w;
    w = '0;
    w.r_view.rd = f.rd[4:0];
    case (f.kind)
      K_LUI: begin
        w.u_view.imm20  = f.imm20;
        w.u_view.opcode = riscv_pkg::OP_LUI;
      end
      K_AUIPC: begin
        w.u_view.imm20  = f.imm20;
        w.u_view.opcode = riscv_pkg::OP_AUIPC;
      end
      K_ADDI: begin
        w.i_view.imm12  = f.imm12;
        w.i_view.opcode = riscv_pkg::OP_OP_IMM;
      end
      default: begin
        w.r_view.funct7 = (f.kind == K_SUB) ? 7'h20 : 7'h00;
        w.r_view.opcode = riscv_pkg::OP_OP;
      end
    endcase
    s = '0;
    s.valid     = 1'b1;
    s.inst      = w;
    s.pc_addr   = f.pc;
    s.rd_valid  = f.rd_valid;
    s.rd_type   = core_pkg::GPR;
    s.rd_rnid   = f.rd;
    s.rs1_valid = f.rs1_valid;
    s.rs1_type  = core_pkg::GPR;
    s.rs1_rnid  = f.rs1;
    s.rs2_valid = f.rs2_valid;
    s.rs2_type  = core_pkg::GPR;
    s.rs2_rnid  = f.rs2;
    return s;
  endfunction

  // RV64 semantics on the model state seen in ex2
  function automatic logic [`XLEN-1:0] expected_result(input flight_t f);
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    imm_u = {{(`XLEN-32){f.imm20[19]}}, f.imm20, 12'h000};
    imm_i = {{(`XLEN-12){f.imm12[11]}}, f.imm12};
    a = f.rs1_valid ? model[f.rs1] : '0;
    b = f.rs2_valid ? model[f.rs2] : '0;
    case (f.kind)
      K_LUI:   return imm_u;
      K_AUIPC: return f.pc + imm_u;
      K_ADD:   return a + b;
      K_SUB:   return a - b;
      K_ADDI:  return a + imm_i;
      default: return '0;
    endcase
  endfunction

  task automatic check_target(input string name, input core_pkg::target_t exp,
                              input core_pkg::target_t act);
    bit bad;
    n_checks++;
    bad = exp.valid ? (act !== exp) : (act.valid !== 1'b0);
    if (bad) begin
      n_errors++;
      $display("Fail %s at cycle %0d: expected %h, actual %h", name, cyc, exp, act);
    end
  endtask

  task automatic check_release(input string name, input core_pkg::release_t exp,
                               input core_pkg::release_t act);
    bit bad;
    n_checks++;
    bad = exp.valid ? (act !== exp) : (act.valid !== 1'b0);
    if (bad) begin
      n_errors++;
      $display("Fail %s at cycle %0d: expected %h, actual %h", name, cyc, exp, act);
    end
  endtask

  task automatic check_index(input string name, input logic [`RV_ENTRY_SIZE-1:0] exp,
                             input logic [`RV_ENTRY_SIZE-1:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("Fail %s at cycle %0d: expected %h, actual %h", name, cyc, exp, act);
    end
  endtask

  // one clock of stimulus, ext write dropped where the pipe could not see it
  task automatic step(input bit do_issue, input flight_t f, input bit do_ext,
                      input logic [`RNID_W-1:0] ext_rnid, input logic [`XLEN-1:0] ext_data);
    int                p;
    bit                use_ext;
    flight_t           g;
    core_pkg::target_t ext;
    @(posedge i_clk);
    cyc = cyc + 1;
    use_ext = do_ext;
    p = find_at(cyc - 1);
    if (p >= 0 && ((q[p].rs1_valid && q[p].rs1 == ext_rnid) ||
                   (q[p].rs2_valid && q[p].rs2 == ext_rnid))) begin
      use_ext = 1'b0;
    end
    p = find_at(cyc - 3);
    if (p >= 0 && q[p].rd_valid && q[p].rd == ext_rnid) begin
      use_ext = 1'b0;
    end
    ext = '0;
    if (use_ext) begin
      ext.valid   = 1'b1;
      ext.rd_type = core_pkg::GPR;
      ext.rd_rnid = ext_rnid;
      ext.rd_data = ext_data;
    end
    i_ext_target <= ext;
    if (do_issue) begin
      g = f;
      g.issue_cyc = cyc;
      g.index = `RV_ENTRY_SIZE'(1) << (n_issued % `RV_ENTRY_SIZE);
      n_issued++;
      q.push_back(g);
      i_issue <= build_issue(g);
      i_index <= g.index;
    end else begin
      i_issue <= '0;
      i_index <= '0;
    end
  endtask

  task automatic issue_inst(input flight_t f, input bit do_ext,
                            input logic [`RNID_W-1:0] ext_rnid,
                            input logic [`XLEN-1:0] ext_data);
    bit ext_left;
    ext_left = do_ext;
    while (needs_bubble(f)) begin
      step(1'b0, f, ext_left, ext_rnid, ext_data);
      ext_left = 1'b0;
    end
    step(1'b1, f, ext_left, ext_rnid, ext_data);
  endtask

  task automatic issue_only(input flight_t f);
    issue_inst(f, 1'b0, '0, '0);
  endtask

  task automatic idle_cycle();
    step(1'b0, '0, 1'b0, '0, '0);
  endtask

  task automatic ext_write(input logic [`RNID_W-1:0] rnid, input logic [`XLEN-1:0] data);
    step(1'b0, '0, 1'b1, rnid, data);
  endtask

  // bus writes of this cycle land in the model before ex2 is evaluated
  always @(negedge i_clk) begin : check_outputs
    int                 front;
    int                 p;
    flight_t            tmp;
    core_pkg::release_t exp_rel;
    core_pkg::target_t  exp_tgt;
    if (checking) begin
      front = find_at(cyc - 3);
      if (front >= 0 && q[front].rd_valid) model[q[front].rd] = q[front].exp_data;
      if (i_ext_target.valid) model[i_ext_target.rd_rnid] = i_ext_target.rd_data;
      p = find_at(cyc - 2);
      if (p >= 0) begin
        tmp = q[p];
        tmp.exp_data = expected_result(tmp);
        q[p] = tmp;
      end
      p = find_at(cyc - 1);
      exp_rel = '0;
      if (p >= 0) begin
        exp_rel.valid   = q[p].rd_valid;
        exp_rel.rd_type = core_pkg::GPR;
        exp_rel.rd_rnid = q[p].rd;
      end
      check_release("release", exp_rel, o_release);
      exp_tgt = '0;
      if (front >= 0) begin
        exp_tgt.valid   = q[front].rd_valid;
        exp_tgt.rd_type = core_pkg::GPR;
        exp_tgt.rd_rnid = q[front].rd;
        exp_tgt.rd_data = q[front].exp_data;
        if (o_done !== 1'b1) begin
          n_errors++;
          $display("done missing at cycle %0d for the instruction issued in cycle %0d",
                   cyc, q[front].issue_cyc);
        end
        check_index("done_index", q[front].index, o_done_index);
        q.delete(front);
      end else if (o_done !== 1'b0) begin
        n_errors++;
        $display("done raised at cycle %0d with no instruction due", cyc);
      end
      check_target("target", exp_tgt, o_target);
    end
  end

  initial begin : run
    flight_t     f;
    logic [31:0] r;
    logic [31:0] e;
    i_clk        = 1'b0;
    i_reset_n    = 1'b0;
    i_issue      = '0;
    i_index      = '0;
    i_ext_target = '0;
    cyc          = '0;
    rng_state    = 32'd43808;
    checking     = 1'b0;
    for (int k = 0; k < `RNID_SIZE; k++) begin
      model[k] = '0;
    end
    repeat (8) @(posedge i_clk);
    i_reset_n <= 1'b1;
    checking = 1'b1;
    repeat (4) idle_cycle();

    // sources written well ahead of their readers
    ext_write(6'd1, 64'h0000_0000_0000_1234);
    ext_write(6'd2, 64'hffff_ffff_ffff_fff0);
    ext_write(6'd3, 64'h7fff_ffff_ffff_ffff);
    ext_write(6'd4, 64'h0000_0000_0000_0005);
    issue_only(make_inst(K_ADD, 6'd10, 6'd1, 6'd2, 32'd0, '0));
    issue_only(make_inst(K_SUB, 6'd11, 6'd3, 6'd4, 32'd0, '0));
    issue_only(make_inst(K_ADDI, 6'd12, 6'd1, 6'd0, 32'hff8, '0));
    issue_only(make_inst(K_ADDI, 6'd13, 6'd2, 6'd0, 32'h7ff, '0));
    issue_only(make_inst(K_SUB, 6'd14, 6'd2, 6'd3, 32'd0, '0));
    issue_only(make_inst(K_LUI, 6'd15, 6'd1, 6'd2, 32'h80001, '0));
    issue_only(make_inst(K_AUIPC, 6'd16, 6'd1, 6'd2, 32'hfffff, 64'h8000_0000_0000_1000));
    issue_only(make_inst(K_LUI, 6'd17, 6'd3, 6'd4, 32'h12345, '0));
    issue_only(make_inst(K_AUIPC, 6'd18, 6'd3, 6'd4, 32'h00010, 64'h40));
    issue_only(make_inst(K_ADD, 6'd19, 6'd40, 6'd41, 32'd0, '0));

    // back to back chain through rs1 and rs2
    issue_only(make_inst(K_ADD, 6'd20, 6'd1, 6'd1, 32'd0, '0));
    issue_only(make_inst(K_ADD, 6'd21, 6'd20, 6'd2, 32'd0, '0));
    issue_only(make_inst(K_ADD, 6'd22, 6'd3, 6'd21, 32'd0, '0));
    issue_only(make_inst(K_SUB, 6'd23, 6'd22, 6'd22, 32'd0, '0));
    issue_only(make_inst(K_ADDI, 6'd24, 6'd23, 6'd0, 32'h001, '0));

    // other unit's result arrives in the consumer's ex2
    issue_only(make_inst(K_ADD, 6'd25, 6'd30, 6'd4, 32'd0, '0));
    idle_cycle();
    ext_write(6'd30, 64'h0123_4567_89ab_cdef);
    issue_only(make_inst(K_SUB, 6'd26, 6'd4, 6'd31, 32'd0, '0));
    idle_cycle();
    ext_write(6'd31, 64'h8000_0000_0000_0001);
    repeat (3) idle_cycle();

    for (int i = 0; i < N_RANDOM; i++) begin
      r = rand32();
      e = rand32();
      if (r[1:0] == 2'b00) begin
        step(1'b0, '0, r[2], `RNID_W'(e[3:0]), {rand32(), rand32()});
      end
      f = make_inst(3'(rand32() % 5), `RNID_W'(r[16:12]), `RNID_W'(r[20:17]),
                    `RNID_W'(r[24:21]), rand32(), {rand32(), rand32() & 32'hffff_fffc});
      f.rd_valid = (r[28:25] != 4'd0);
      issue_inst(f, e[5:4] == 2'b00, `RNID_W'(e[11:8]), {rand32(), rand32()});
    end

    while (q.size() != 0) begin
      idle_cycle();
    end
    repeat (4) idle_cycle();

    $display("issued %0d, checks %0d, errors %0d", n_issued, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/alu_subsystem_top.sv ====
`timescale 1ns/10ps
`include "core_settings.svh"

module alu_subsystem_top (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  core_pkg::issue_t           i_issue,
  input  logic [`RV_ENTRY_SIZE-1:0]  i_index,
  input  core_pkg::target_t          i_ext_target,
  output core_pkg::release_t         o_release,
  output core_pkg::target_t          o_target,
  output logic                       o_done,
  output logic [`RV_ENTRY_SIZE-1:0]  o_done_index
);

  core_pkg::target_t       w_alu_target;
  core_pkg::target_t       w_tgt_bus [`TGT_BUS_SIZE];
  core_pkg::regread_req_t  w_rd_req [2];
  logic [`XLEN-1:0]        w_rd_data [2];

  // lane 0 own result, lane 1 the other unit
  assign w_tgt_bus[0] = w_alu_target;
  assign w_tgt_bus[1] = i_ext_target;
  assign o_target     = w_alu_target;

  alu_pipe u_alu_pipe (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_issue      (i_issue),
    .i_index      (i_index),
    .o_rs1_req    (w_rd_req[0]),
    .o_rs2_req    (w_rd_req[1]),
    .i_rs1_data   (w_rd_data[0]),
    .i_rs2_data   (w_rd_data[1]),
    .i_target     (w_tgt_bus),
    .o_release    (o_release),
    .o_target     (w_alu_target),
    .o_done       (o_done),
    .o_done_index (o_done_index)
  );

  phys_regfile u_regfile (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_rd_req    (w_rd_req),
    .o_rd_data   (w_rd_data),
    .i_wr_target (w_tgt_bus)
  );

endmodule

// ==== alu_pipe/alu_pipe.sv ====
`timescale 1ns/10ps
`include "core_settings.svh"

module alu_pipe (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  core_pkg::issue_t           i_issue,
  input  logic [`RV_ENTRY_SIZE-1:0]  i_index,
  output core_pkg::regread_req_t     o_rs1_req,
  output core_pkg::regread_req_t     o_rs2_req,
  input  logic [`XLEN-1:0]           i_rs1_data,
  input  logic [`XLEN-1:0]           i_rs2_data,
  input  core_pkg::target_t          i_target [`TGT_BUS_SIZE],
  output core_pkg::release_t         o_release,
  output core_pkg::target_t          o_target,
  output logic                       o_done,
  output logic [`RV_ENTRY_SIZE-1:0]  o_done_index
);

  core_pkg::pipe_ctrl_t              w_ex0_ctrl;

  core_pkg::issue_t                  r_ex1_issue;
  logic [`RV_ENTRY_SIZE-1:0]         r_ex1_index;
  core_pkg::pipe_ctrl_t              r_ex1_ctrl;
  logic [`XLEN-1:0]                  w_ex1_imm_i;

  core_pkg::issue_t                  r_ex2_issue;
  logic [`RV_ENTRY_SIZE-1:0]         r_ex2_index;
  core_pkg::pipe_ctrl_t              r_ex2_ctrl;
  logic [`XLEN-1:0]                  r_ex2_rs1_data;
  logic [`XLEN-1:0]                  r_ex2_rs2_data;
  logic [`TGT_BUS_SIZE-1:0]          w_ex2_rs1_hit;
  logic [`TGT_BUS_SIZE-1:0]          w_ex2_rs2_hit;
  logic [`XLEN-1:0]                  w_ex2_tgt_data [`TGT_BUS_SIZE];
  logic [`XLEN-1:0]                  w_ex2_rs1_fwd;
  logic [`XLEN-1:0]                  w_ex2_rs2_fwd;
  logic [`XLEN-1:0]                  w_ex2_rs1;
  logic [`XLEN-1:0]                  w_ex2_rs2;
  logic [`XLEN-1:0]                  w_ex2_imm_u;
  logic [`XLEN-1:0]                  w_ex2_result;

  core_pkg::issue_t                  r_ex3_issue;
  logic [`RV_ENTRY_SIZE-1:0]         r_ex3_index;
  logic [`XLEN-1:0]                  r_ex3_result;

  // ex0: decode and register read
  alu_inst_decoder u_decoder (
    .i_inst (i_issue.inst),
    .o_ctrl (w_ex0_ctrl)
  );

  assign o_rs1_req.valid = i_issue.valid & i_issue.rs1_valid;
  assign o_rs1_req.rnid  = i_issue.rs1_rnid;
  assign o_rs2_req.valid = i_issue.valid & i_issue.rs2_valid;
  assign o_rs2_req.rnid  = i_issue.rs2_rnid;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_index <= '0;
      r_ex1_ctrl  <= '0;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex1_index <= i_index;
      r_ex1_ctrl  <= w_ex0_ctrl;
    end
  end

  // ex1: release and immediate select
  assign o_release.valid   = r_ex1_issue.valid & r_ex1_issue.rd_valid;
  assign o_release.rd_type = r_ex1_issue.rd_type;
  assign o_release.rd_rnid = r_ex1_issue.rd_rnid;

  assign w_ex1_imm_i = {{(`XLEN-12){r_ex1_issue.inst.i_view.imm12[11]}},
                        r_ex1_issue.inst.i_view.imm12};

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_issue <= '0;
      r_ex2_index <= '0;
      r_ex2_ctrl  <= '0;
    end else begin
      r_ex2_issue <= r_ex1_issue;
      r_ex2_index <= r_ex1_index;
      r_ex2_ctrl  <= r_ex1_ctrl;
    end
  end

  // register file data arrives in ex1
  always_ff @(posedge i_clk) begin
    r_ex2_rs1_data <= i_rs1_data;
    r_ex2_rs2_data <= r_ex1_ctrl.imm ? w_ex1_imm_i : i_rs2_data;
  end

  // ex2: forwarding from the result bus
  for (genvar l = 0; l < `TGT_BUS_SIZE; l++) begin : g_fwd
    assign w_ex2_rs1_hit[l] = r_ex2_issue.valid & r_ex2_issue.rs1_valid & i_target[l].valid &
                              (r_ex2_issue.rs1_type == i_target[l].rd_type) &
                              (r_ex2_issue.rs1_rnid == i_target[l].rd_rnid);
    // addi has no rs2, the immediate must survive
    assign w_ex2_rs2_hit[l] = r_ex2_issue.valid & r_ex2_issue.rs2_valid & ~r_ex2_ctrl.imm &
                              i_target[l].valid &
                              (r_ex2_issue.rs2_type == i_target[l].rd_type) &
                              (r_ex2_issue.rs2_rnid == i_target[l].rd_rnid);
    assign w_ex2_tgt_data[l] = i_target[l].rd_data;
  end

  bit_oh_or #(
    .WIDTH (`XLEN),
    .WORDS (`TGT_BUS_SIZE)
  ) u_rs1_fwd_sel (
    .i_oh       (w_ex2_rs1_hit),
    .i_data     (w_ex2_tgt_data),
    .o_selected (w_ex2_rs1_fwd)
  );

  bit_oh_or #(
    .WIDTH (`XLEN),
    .WORDS (`TGT_BUS_SIZE)
  ) u_rs2_fwd_sel (
    .i_oh       (w_ex2_rs2_hit),
    .i_data     (w_ex2_tgt_data),
    .o_selected (w_ex2_rs2_fwd)
  );

  assign w_ex2_rs1 = (|w_ex2_rs1_hit) ? w_ex2_rs1_fwd : r_ex2_rs1_data;
  assign w_ex2_rs2 = (|w_ex2_rs2_hit) ? w_ex2_rs2_fwd : r_ex2_rs2_data;

  assign w_ex2_imm_u = {{(`XLEN-32){r_ex2_issue.inst.u_view.imm20[19]}},
                        r_ex2_issue.inst.u_view.imm20, 12'h000};

  always_comb begin
    case (r_ex2_ctrl.op)
      core_pkg::LUI:   w_ex2_result = w_ex2_imm_u;
      core_pkg::AUIPC: w_ex2_result = r_ex2_issue.pc_addr + w_ex2_imm_u;
      core_pkg::ADD:   w_ex2_result = w_ex2_rs1 + w_ex2_rs2;
      core_pkg::SUB:   w_ex2_result = w_ex2_rs1 - w_ex2_rs2;
      default:         w_ex2_result = '0;
    endcase
  end

  // ex3: result onto bus lane 0
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_issue <= '0;
      r_ex3_index <= '0;
    end else begin
      r_ex3_issue <= r_ex2_issue;
      r_ex3_index <= r_ex2_index;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex3_result <= w_ex2_result;
  end

  assign o_target.valid   = r_ex3_issue.valid & r_ex3_issue.rd_valid;
  assign o_target.rd_type = r_ex3_issue.rd_type;
  assign o_target.rd_rnid = r_ex3_issue.rd_rnid;
  assign o_target.rd_data = r_ex3_result;

  assign o_done       = r_ex3_issue.valid;
  assign o_done_index = r_ex3_index;

  // index travelled three stages from issue
  a_done_index_onehot : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done |-> $onehot(o_done_index))
    else $error("alu_pipe: done index %h is not one-hot", o_done_index);

endmodule

// ==== logic/phys_regfile.sv ====
`timescale 1ns/10ps
`include "core_settings.svh"

module phys_regfile (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  core_pkg::regread_req_t  i_rd_req [2],
  output logic [`XLEN-1:0]        o_rd_data [2],
  input  core_pkg::target_t       i_wr_target [`TGT_BUS_SIZE]
);

  logic [`XLEN-1:0] r_regs [`RNID_SIZE];
  logic [`XLEN-1:0] w_rd_next [2];

  // one write port per bus lane, fpr results go elsewhere
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int e = 0; e < `RNID_SIZE; e++) begin
        r_regs[e] <= '0;
      end
    end else begin
      for (int l = 0; l < `TGT_BUS_SIZE; l++) begin
        if (i_wr_target[l].valid && (i_wr_target[l].rd_type == core_pkg::GPR)) begin
          r_regs[i_wr_target[l].rd_rnid] <= i_wr_target[l].rd_data;
        end
      end
    end
  end

  // write-first, a same-edge write wins over the array
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      w_rd_next[p] = r_regs[i_rd_req[p].rnid];
      for (int l = 0; l < `TGT_BUS_SIZE; l++) begin
        if (i_wr_target[l].valid && (i_wr_target[l].rd_type == core_pkg::GPR) &&
            (i_wr_target[l].rd_rnid == i_rd_req[p].rnid)) begin
          w_rd_next[p] = i_wr_target[l].rd_data;
        end
      end
    end
  end

  // read data holds between requests
  always_ff @(posedge i_clk) begin
    for (int p = 0; p < 2; p++) begin
      if (i_rd_req[p].valid) begin
        o_rd_data[p] <= w_rd_next[p];
      end
    end
  end

  // two lanes on one register leave the stored value undefined
  for (genvar a = 0; a < `TGT_BUS_SIZE; a++) begin : g_lane_a
    for (genvar b = a + 1; b < `TGT_BUS_SIZE; b++) begin : g_lane_b
      a_unique_rnid : assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(i_wr_target[a].valid && i_wr_target[b].valid &&
          (i_wr_target[a].rd_type == i_wr_target[b].rd_type) &&
          (i_wr_target[a].rd_rnid == i_wr_target[b].rd_rnid)))
        else $error("phys_regfile: lanes %0d and %0d both write rnid %0d",
                    a, b, i_wr_target[a].rd_rnid);
    end
  end

endmodule

// ==== logic/alu_inst_decoder.sv ====
`timescale 1ns/10ps

module alu_inst_decoder (
  input  riscv_pkg::inst_t      i_inst,
  output core_pkg::pipe_ctrl_t  o_ctrl
);

  always_comb begin
    o_ctrl.op  = core_pkg::NONE;
    o_ctrl.imm = 1'b0;

    case (i_inst.r_view.opcode)
      riscv_pkg::OP_LUI: begin
        o_ctrl.op = core_pkg::LUI;
      end
      riscv_pkg::OP_AUIPC: begin
        o_ctrl.op = core_pkg::AUIPC;
      end
      riscv_pkg::OP_OP: begin
        // funct7 bit 5 picks sub over add
        if (i_inst.r_view.funct3 == 3'b000) begin
          o_ctrl.op = i_inst.r_view.funct7[5] ? core_pkg::SUB : core_pkg::ADD;
        end
      end
      riscv_pkg::OP_OP_IMM: begin
        // addi only
        if (i_inst.i_view.funct3 == 3'b000) begin
          o_ctrl.op  = core_pkg::ADD;
          o_ctrl.imm = 1'b1;
        end
      end
      default: begin
        o_ctrl.op = core_pkg::NONE;
      end
    endcase
  end

endmodule

// ==== logic/bit_oh_or.sv ====
`timescale 1ns/10ps

module bit_oh_or #(
  parameter int WIDTH = 32,
  parameter int WORDS = 4
) (
  input  logic [WORDS-1:0] i_oh,
  input  logic [WIDTH-1:0] i_data [WORDS],
  output logic [WIDTH-1:0] o_selected
);

  // and-or mux, no priority
  always_comb begin
    o_selected = '0;
    for (int w = 0; w < WORDS; w++) begin
      o_selected = o_selected | (i_data[w] & {WIDTH{i_oh[w]}});
    end
  end

  // two hot bits would merge two words silently
  always_comb begin
    if (!$isunknown(i_oh)) begin
      a_onehot0 : assert final ($onehot0(i_oh))
        else $error("bit_oh_or: select %b is not one-hot", i_oh);
    end
  end

endmodule

// ==== common/core_pkg.sv ====
`include "core_settings.svh"

package core_pkg;

  typedef enum logic {
    GPR = 1'b0,
    FPR = 1'b1
  } reg_type_t;

  typedef struct packed {
    logic                 valid;
    riscv_pkg::inst_t     inst;
    logic [`XLEN-1:0]     pc_addr;
    logic                 rd_valid;
    reg_type_t            rd_type;
    logic [`RNID_W-1:0]   rd_rnid;
    logic                 rs1_valid;
    reg_type_t            rs1_type;
    logic [`RNID_W-1:0]   rs1_rnid;
    logic                 rs2_valid;
    reg_type_t            rs2_type;
    logic [`RNID_W-1:0]   rs2_rnid;
  } issue_t;

  // one lane of the result bus
  typedef struct packed {
    logic                 valid;
    reg_type_t            rd_type;
    logic [`RNID_W-1:0]   rd_rnid;
    logic [`XLEN-1:0]     rd_data;
  } target_t;

  // early notice of the destination, ahead of the data
  typedef struct packed {
    logic                 valid;
    reg_type_t            rd_type;
    logic [`RNID_W-1:0]   rd_rnid;
  } release_t;

  typedef struct packed {
    logic                 valid;
    logic [`RNID_W-1:0]   rnid;
  } regread_req_t;

  typedef enum logic [2:0] {
    NONE  = 3'd0,
    LUI   = 3'd1,
    AUIPC = 3'd2,
    ADD   = 3'd3,
    SUB   = 3'd4
  } alu_op_t;

  typedef struct packed {
    alu_op_t op;
    logic    imm;
  } pipe_ctrl_t;

endpackage

// ==== common/riscv_pkg.sv ====
package riscv_pkg;

  typedef logic [6:0] opcode_t;

  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_OP     = 7'b0110011;
  localparam opcode_t OP_OP_IMM = 7'b0010011;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } i_type_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    opcode_t     opcode;
  } u_type_t;

  // same 32 bits, decoded per format
  typedef union packed {
    r_type_t r_view;
    i_type_t i_view;
    u_type_t u_view;
  } inst_t;

endpackage

// ==== common/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// integer datapath width
`define XLEN 64

// renamed register id width and the entry count it implies
`define RNID_W 6
`define RNID_SIZE (1 << `RNID_W)

// lanes on the result bus
// lane 0 is the alu pipe, lane 1 another unit
`define TGT_BUS_SIZE 2

// one-hot reservation station index
`define RV_ENTRY_SIZE 16

`endif
